// ==== ps2_pkg.sv ====
package ps2_pkg;

    parameter int DATA_W = 8;   // one PS/2 data byte
    parameter int CNT_W  = 8;   // saturating error counters
    parameter int APB_W  = 32;

    // register offsets
    parameter logic [APB_W-1:0] ADDR_DATA   = 32'h0;
    parameter logic [APB_W-1:0] ADDR_STATUS = 32'h4;
    parameter logic [APB_W-1:0] ADDR_CTRL   = 32'h8;

    // start bit is taken in ST_IDLE
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_DATA   = 2'd1,
        ST_PARITY = 2'd2,
        ST_STOP   = 2'd3
    } ps2_state_t;

endpackage

// ==== fifo_if.sv ====
`timescale 1ns/100ps

interface fifo_if import ps2_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) ();
    localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

    logic              push;
    logic [DATA_W-1:0] wdata;
    logic              pop;
    logic [DATA_W-1:0] rdata;   // head of queue
    logic              full;
    logic              empty;
    logic [LVL_W-1:0]  level;   // bytes held

    modport writer (output push, output wdata, input full);

    modport fifo (
        input  push, wdata, pop,
        output full, empty, rdata, level
    );

    modport reader (output pop, input rdata, input empty, input full);

endinterface

// ==== ps2_frame_fsm.sv ====
`timescale 1ns/100ps

module ps2_frame_fsm import ps2_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       ps2_clk_i,
    input  logic       ps2_data_i,
    input  logic       enable_i,
    input  logic       last_bit_i,
    input  logic       abort_i,
    output logic       fall_o,
    output logic       data_bit_o,
    output ps2_state_t state_o
);
    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    ps2_state_t state_d;

    // both lines idle high on the bus
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk_i};
            data_sync <= {data_sync[0], ps2_data_i};
            clk_prev  <= clk_sync[1];
        end
    end

    // edges are not passed on while disabled
    assign fall_o     = clk_prev & ~clk_sync[1] & enable_i;
    assign data_bit_o = data_sync[1];

    always_comb begin
        state_d = state_o;
        if (!enable_i || abort_i) begin
            state_d = ST_IDLE;
        end else if (fall_o) begin
            case (state_o)
                ST_IDLE: begin
                    if (!data_bit_o) begin   // start bit must be 0
                        state_d = ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (last_bit_i) begin
                        state_d = ST_PARITY;
                    end
                end
                ST_PARITY: begin
                    state_d = ST_STOP;
                end
                ST_STOP: begin
                    state_d = ST_IDLE;      // frame done
                end
                default: begin
                    state_d = ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_o <= ST_IDLE;
        end else begin
            state_o <= state_d;
        end
    end

endmodule

// ==== ps2_bit_timer.sv ====
`timescale 1ns/100ps

module ps2_bit_timer import ps2_pkg::*; #(
    parameter int TIMEOUT_CYCLES = 2000
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       fall_i,
    input  ps2_state_t state_i,
    output logic       last_bit_o,
    output logic       abort_o
);
    localparam int TMR_W = $clog2(TIMEOUT_CYCLES);

    logic [2:0]       bit_cnt;
    logic [TMR_W-1:0] stall_cnt;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bit_cnt <= 3'd0;
        end else if (state_i != ST_DATA) begin
            bit_cnt <= 3'd0;
        end else if (fall_i) begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    assign last_bit_o = (state_i == ST_DATA) && (bit_cnt == 3'd7);

    // reloads on every edge, runs only inside a frame
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stall_cnt <= '0;
        end else if (fall_i || state_i == ST_IDLE || abort_o) begin
            stall_cnt <= '0;
        end else begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    assign abort_o = (state_i != ST_IDLE) && !fall_i &&
                     (stall_cnt == TMR_W'(TIMEOUT_CYCLES - 1));

endmodule

// ==== ps2_shift_check.sv ====
`timescale 1ns/100ps

module ps2_shift_check import ps2_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             fall_i,
    input  logic             data_bit_i,
    input  ps2_state_t       state_i,
    input  logic             abort_i,
    input  logic             clear_i,
    fifo_if.writer           wr,
    output logic [CNT_W-1:0] parity_errs_o,
    output logic [CNT_W-1:0] frame_errs_o,
    output logic [CNT_W-1:0] overruns_o
);
    logic [DATA_W-1:0] shreg;
    logic              parity;     // xor of data and parity bits
    logic              stop_edge;
    logic              byte_ok;
    logic              parity_bad;
    logic              frame_bad;
    logic              overrun;

    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] cnt,
                                                 input logic inc);
        if (inc && cnt != '1) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    always_ff @(posedge clock) begin
        if (fall_i && state_i == ST_DATA) begin
            shreg <= {data_bit_i, shreg[DATA_W-1:1]};  // lsb first
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            parity <= 1'b0;
        end else if (fall_i) begin
            if (state_i == ST_IDLE) begin
                parity <= 1'b0;
            end else if (state_i == ST_DATA || state_i == ST_PARITY) begin
                parity <= parity ^ data_bit_i;
            end
        end
    end

    assign stop_edge  = fall_i && (state_i == ST_STOP);
    assign parity_bad = stop_edge && !parity;
    assign byte_ok    = stop_edge && parity && data_bit_i;
    assign frame_bad  = abort_i || (fall_i && state_i == ST_IDLE && data_bit_i) ||
                        (stop_edge && !data_bit_i);
    assign overrun    = byte_ok && wr.full;

    assign wr.push  = byte_ok && !wr.full;
    assign wr.wdata = shreg;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            parity_errs_o <= '0;
            frame_errs_o  <= '0;
            overruns_o    <= '0;
        end else if (clear_i) begin
            parity_errs_o <= '0;
            frame_errs_o  <= '0;
            overruns_o    <= '0;
        end else begin
            parity_errs_o <= sat_inc(parity_errs_o, parity_bad);
            frame_errs_o  <= sat_inc(frame_errs_o, frame_bad);
            overruns_o    <= sat_inc(overruns_o, overrun);
        end
    end

endmodule

// ==== ps2_fifo.sv ====
`timescale 1ns/100ps

module ps2_fifo import ps2_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic clock,
    input  logic reset,
    fifo_if.fifo q
);
    localparam int AW = $clog2(FIFO_DEPTH);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [AW:0]       wr_ptr;    // msb is the wrap bit
    logic [AW:0]       rd_ptr;
    logic              do_push;
    logic              do_pop;

    assign do_push = q.push && !q.full;
    assign do_pop  = q.pop && !q.empty;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= q.wdata;
        end
    end

    assign q.level = wr_ptr - rd_ptr;
    assign q.full  = (q.level == (AW + 1)'(FIFO_DEPTH));
    assign q.empty = (q.level == '0);
    assign q.rdata = mem[rd_ptr[AW-1:0]];

endmodule

// ==== ps2_apb_regs.sv ====
`timescale 1ns/100ps

module ps2_apb_regs import ps2_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic [APB_W-1:0] paddr_i,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  logic [APB_W-1:0] pwdata_i,
    output logic             pready_o,
    output logic [APB_W-1:0] prdata_o,
    output logic             pslverr_o,
    fifo_if.reader           rd,
    input  logic [CNT_W-1:0] parity_errs_i,
    input  logic [CNT_W-1:0] frame_errs_i,
    input  logic [CNT_W-1:0] overruns_i,
    output logic             enable_o,
    output logic             clear_o
);
    logic              access;
    logic              hit_data;
    logic              hit_status;
    logic              hit_ctrl;
    logic              valid;
    logic [DATA_W-1:0] head;

    assign access     = psel_i && penable_i;
    assign hit_data   = (paddr_i == ADDR_DATA);
    assign hit_status = (paddr_i == ADDR_STATUS);
    assign hit_ctrl   = (paddr_i == ADDR_CTRL);

    // zero wait states
    assign pready_o  = access;
    assign pslverr_o = access && !(hit_data || hit_status || hit_ctrl);

    assign valid = !rd.empty;
    assign head  = valid ? rd.rdata : '0;   // storage is stale when empty

    assign rd.pop = access && !pwrite_i && hit_data && valid;

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            if (hit_data) begin
                prdata_o = {{(APB_W - DATA_W - 1){1'b0}}, valid, head};
            end else if (hit_status) begin
                prdata_o = {overruns_i, frame_errs_i, parity_errs_i,
                            6'b0, rd.full, rd.empty};
            end else if (hit_ctrl) begin
                prdata_o = {{(APB_W - 1){1'b0}}, enable_o};
            end
        end
    end

    // bit 1 of a ctrl write clears the counters
    assign clear_o = access && pwrite_i && hit_ctrl && pwdata_i[1];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            enable_o <= 1'b1;   // receiving out of reset
        end else if (access && pwrite_i && hit_ctrl) begin
            enable_o <= pwdata_i[0];
        end
    end

endmodule

// ==== ps2_rx_apb.sv ====
`timescale 1ns/100ps

module ps2_rx_apb import ps2_pkg::*; #(
    parameter int FIFO_DEPTH     = 8,
    parameter int TIMEOUT_CYCLES = 2000
) (
    input  logic             clock,
    input  logic             reset,
    input  logic [APB_W-1:0] paddr_i,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  logic [APB_W-1:0] pwdata_i,
    output logic             pready_o,
    output logic [APB_W-1:0] prdata_o,
    output logic             pslverr_o,
    input  logic             ps2_clk_i,
    input  logic             ps2_data_i
);
    logic             fall;
    logic             data_bit;
    ps2_state_t       state;
    logic             last_bit;
    logic             abort;
    logic             enable;
    logic             clear;
    logic [CNT_W-1:0] parity_errs;
    logic [CNT_W-1:0] frame_errs;
    logic [CNT_W-1:0] overruns;

    fifo_if #(.FIFO_DEPTH(FIFO_DEPTH)) q_if ();

    ps2_frame_fsm u_fsm (
        .clock      (clock),
        .reset      (reset),
        .ps2_clk_i  (ps2_clk_i),
        .ps2_data_i (ps2_data_i),
        .enable_i   (enable),
        .last_bit_i (last_bit),
        .abort_i    (abort),
        .fall_o     (fall),
        .data_bit_o (data_bit),
        .state_o    (state)
    );

    ps2_bit_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_timer (
        .clock      (clock),
        .reset      (reset),
        .fall_i     (fall),
        .state_i    (state),
        .last_bit_o (last_bit),
        .abort_o    (abort)
    );

    ps2_shift_check u_check (
        .clock         (clock),
        .reset         (reset),
        .fall_i        (fall),
        .data_bit_i    (data_bit),
        .state_i       (state),
        .abort_i       (abort),
        .clear_i       (clear),
        .wr            (q_if.writer),
        .parity_errs_o (parity_errs),
        .frame_errs_o  (frame_errs),
        .overruns_o    (overruns)
    );

    ps2_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clock (clock),
        .reset (reset),
        .q     (q_if.fifo)
    );

    ps2_apb_regs u_regs (
        .clock         (clock),
        .reset         (reset),
        .paddr_i       (paddr_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .pwdata_i      (pwdata_i),
        .pready_o      (pready_o),
        .prdata_o      (prdata_o),
        .pslverr_o     (pslverr_o),
        .rd            (q_if.reader),
        .parity_errs_i (parity_errs),
        .frame_errs_i  (frame_errs),
        .overruns_i    (overruns),
        .enable_o      (enable),
        .clear_o       (clear)
    );

endmodule

// ==== tb_ps2_rx.sv ====
`timescale 1ns/100ps

module tb_ps2_rx import ps2_pkg::*; ();
    localparam int HALF       = 40;                 // ps2 half period in clocks
    localparam int FRAME_NS   = 11 * 2 * HALF * 4;
    localparam int DEPTH      = 8;
    localparam int POLL_LIMIT = 2000;

    typedef enum int {OP_NONE, OP_DISABLE, OP_ENABLE_CLEAR, OP_BADADDR} op_t;
    typedef enum int {K_NONE, K_GOOD, K_PARITY, K_STOP, K_TRUNC} kind_t;

    typedef struct packed {
        int         op;
        int         kind;
        int         nreads;
        logic [7:0] data;
    } row_t;

    logic        clock;
    logic        reset;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
    logic        ps2_clk;
    logic        ps2_data;

    row_t        rows[$];
    logic [7:0]  model_q[$];                        // bytes the FIFO should hold
    logic [7:0]  par_cnt = 0;
    logic [7:0]  frm_cnt = 0;
    logic [7:0]  ovr_cnt = 0;
    logic        enabled = 1'b1;

    ps2_rx_apb #(.FIFO_DEPTH(DEPTH), .TIMEOUT_CYCLES(2000)) DUT (
        .clock      (clock),
        .reset      (reset),
        .paddr_i    (paddr),
        .psel_i     (psel),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .pwdata_i   (pwdata),
        .pready_o   (pready),
        .prdata_o   (prdata),
        .pslverr_o  (pslverr),
        .ps2_clk_i  (ps2_clk),
        .ps2_data_i (ps2_data)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH at %0t: %s got %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    // setup cycle, then access cycle sampled mid-cycle
    task automatic apb_access(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                              input logic exp_err, output logic [31:0] rdata);
        @(posedge clock);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clock);
        penable <= 1'b1;
        @(negedge clock);
        check("pready_o", pready, 1'b1);
        check("pslverr_o", pslverr, exp_err);
        rdata = prdata;
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, input logic exp_err,
                            output logic [31:0] rdata);
        apb_access(addr, 1'b0, 32'h0, exp_err, rdata);
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic exp_err);
        logic [31:0] unused;
        apb_access(addr, 1'b1, wdata, exp_err, unused);
    endtask

    // device changes data while the ps2 clock is high
    task automatic send_frame(input logic [7:0] b, input int kind);
        logic [10:0] bits;
        int          nbits;
        bits  = {1'b1, ~^b, b, 1'b0};               // stop, odd parity, data, start
        nbits = 11;
        if (kind == K_PARITY) bits[9] = ~bits[9];
        if (kind == K_STOP) bits[10] = 1'b0;
        if (kind == K_TRUNC) nbits = 5;
        for (int i = 0; i < nbits; i++) begin
            @(posedge clock);
            ps2_data <= bits[i];
            repeat (HALF) @(posedge clock);
            ps2_clk <= 1'b0;
            repeat (HALF) @(posedge clock);
            ps2_clk <= 1'b1;
        end
        @(posedge clock);
        ps2_data <= 1'b1;
        repeat (HALF) @(posedge clock);
    endtask

    task automatic model_frame(input row_t row);
        if (!enabled) return;                        // receiver ignores the line
        case (row.kind)
            K_GOOD: begin
                if (model_q.size() < DEPTH) model_q.push_back(row.data);
                else ovr_cnt++;
            end
            K_PARITY: par_cnt++;
            K_STOP, K_TRUNC: frm_cnt++;
            default: ;
        endcase
    endtask

    function automatic logic [31:0] expected_status();
        return {ovr_cnt, frm_cnt, par_cnt, 6'b0, model_q.size() == DEPTH, model_q.size() == 0};
    endfunction

    task automatic wait_status(input logic [31:0] exp);
        logic [31:0] st;
        int          polls;
        polls = 0;
        apb_read(ADDR_STATUS, 1'b0, st);
        while (st !== exp && polls < POLL_LIMIT) begin
            apb_read(ADDR_STATUS, 1'b0, st);
            polls++;
        end
        check("STATUS", st, exp);
    endtask

    task automatic run_row(input row_t row);
        logic [31:0] rd;
        logic [31:0] exp;
        case (row.op)
            OP_DISABLE: begin
                apb_write(ADDR_CTRL, 32'h0, 1'b0);
                enabled = 1'b0;
            end
            OP_ENABLE_CLEAR: begin
                apb_write(ADDR_CTRL, 32'h3, 1'b0);
                enabled = 1'b1;
                par_cnt = 0;
                frm_cnt = 0;
                ovr_cnt = 0;
            end
            OP_BADADDR: begin
                apb_read(32'hC, 1'b1, rd);
                apb_write(32'hC, 32'h1, 1'b1);
            end
            default: ;
        endcase
        apb_read(ADDR_CTRL, 1'b0, rd);
        check("CTRL", rd, {31'b0, enabled});
        if (row.kind != K_NONE) begin
            send_frame(row.data, row.kind);
            model_frame(row);
        end
        wait_status(expected_status());
        repeat (row.nreads) begin
            if (model_q.size() > 0) exp = {23'b0, 1'b1, model_q.pop_front()};
            else exp = 32'h0;
            apb_read(ADDR_DATA, 1'b0, rd);
            check("DATA", rd, exp);
        end
    endtask

    function automatic void add_row(input int op, input int kind, input int nreads);
        row_t r;
        r.op     = op;
        r.kind   = kind;
        r.nreads = nreads;
        r.data   = 8'($urandom());
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        add_row(OP_NONE, K_GOOD, 1);
        add_row(OP_NONE, K_GOOD, 0);
        add_row(OP_NONE, K_GOOD, 1);
        add_row(OP_NONE, K_NONE, 2);                 // last byte, then empty
        add_row(OP_NONE, K_PARITY, 0);
        add_row(OP_NONE, K_STOP, 0);
        for (int i = 0; i < 10; i++) add_row(OP_NONE, K_GOOD, 0);  // two overruns
        add_row(OP_NONE, K_NONE, 9);
        add_row(OP_NONE, K_TRUNC, 0);
        add_row(OP_NONE, K_GOOD, 1);
        add_row(OP_DISABLE, K_GOOD, 1);
        add_row(OP_ENABLE_CLEAR, K_NONE, 0);
        add_row(OP_NONE, K_GOOD, 1);
        add_row(OP_BADADDR, K_NONE, 0);
    endfunction

    initial begin
        int limit_ns;
        reset    <= 1'b1;
        paddr    <= 32'h0;
        psel     <= 1'b0;
        penable  <= 1'b0;
        pwrite   <= 1'b0;
        pwdata   <= 32'h0;
        ps2_clk  <= 1'b1;
        ps2_data <= 1'b1;
        void'($urandom(32'h2b74bd82));
        build_table();
        limit_ns = rows.size() * 30 * FRAME_NS + 20000;
        fork
            begin
                #(limit_ns);
                stop_on_error($sformatf("watchdog: run did not finish within %0d ns", limit_ns));
            end
        join_none
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        foreach (rows[r]) run_row(rows[r]);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== list.f ====
ps2_pkg.sv
fifo_if.sv
ps2_frame_fsm.sv
ps2_bit_timer.sv
ps2_shift_check.sv
ps2_fifo.sv
ps2_apb_regs.sv
ps2_rx_apb.sv
tb_ps2_rx.sv
